// ==== Makefile ====
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/cpu_pkg.sv ====
// widths, opcodes, function codes, fetch addresses, exception codes and stage structs
package cpu_pkg;

    localparam int XLEN   = 32;  // data and address width
    localparam int REG_AW = 5;   // 32 architectural registers

    localparam logic [XLEN-1:0] RESET_PC   = 32'h0040_0000;  // first fetch after reset
    localparam logic [XLEN-1:0] EXC_VECTOR = 32'h0040_0180;  // handler entry

    // major opcodes, bits 31:26
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;

    // R-type function codes, bits 5:0
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4   // signed compare
    } alu_op_t;

    typedef enum logic [2:0] {
        EXC_NONE       = 3'd0,
        EXC_ILLEGAL    = 3'd1,  // raised in decode
        EXC_OVERFLOW   = 3'd2,  // raised in execute
        EXC_ZERO_WRITE = 3'd7   // raised in result stage
    } exc_code_t;

    // decode to execute
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        alu_op_t           alu_op;
        logic [XLEN-1:0]   opa;         // forwarded rs
        logic [XLEN-1:0]   opb;         // forwarded rt or sign-extended immediate
        logic [REG_AW-1:0] dest;
        logic              writes_reg;
        logic              checks_ovf;  // add, sub, addi
        exc_code_t         exc;
    } dec_ex_t;

    // execute to result, also the forwarding payload
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] dest;
        logic              writes_reg;
        logic [XLEN-1:0]   data;
        exc_code_t         exc;
    } ex_res_t;

endpackage

// ==== decode/instr_decode.sv ====
// instr_decode: PC, fetch register, decode, illegal-instruction check and operand forwarding
`timescale 1ns/1ps

module instr_decode (
    input  logic                         SYS_clk,
    input  logic                         SYS_reset,
    input  logic                         flush,
    output logic [cpu_pkg::XLEN-1:0]     imem_addr,
    input  logic [cpu_pkg::XLEN-1:0]     imem_data,
    output logic [cpu_pkg::REG_AW-1:0]   rd_addr_a,
    output logic [cpu_pkg::REG_AW-1:0]   rd_addr_b,
    input  logic [cpu_pkg::XLEN-1:0]     rd_data_a,
    input  logic [cpu_pkg::XLEN-1:0]     rd_data_b,
    input  cpu_pkg::ex_res_t             ex_fwd,
    input  cpu_pkg::ex_res_t             res_fwd,
    output cpu_pkg::dec_ex_t             dec_out
);

    logic [cpu_pkg::XLEN-1:0]   pc_q;
    logic [cpu_pkg::XLEN-1:0]   fetch_pc_q;
    logic [cpu_pkg::XLEN-1:0]   fetch_word_q;
    logic                       fetch_valid_q;

    logic [5:0]                 opcode;
    logic [5:0]                 funct;
    logic [cpu_pkg::REG_AW-1:0] rs;
    logic [cpu_pkg::REG_AW-1:0] rt;
    logic [cpu_pkg::REG_AW-1:0] rd;
    logic [cpu_pkg::XLEN-1:0]   imm_ext;
    logic                       is_rtype;
    logic                       is_addi;
    logic                       funct_ok;
    logic                       legal;
    logic                       slot_valid;
    cpu_pkg::alu_op_t           rtype_op;
    logic [cpu_pkg::XLEN-1:0]   op_a;
    logic [cpu_pkg::XLEN-1:0]   op_b;

    // a younger reader may take this producer's value
    function automatic logic fwd_hit(
        input cpu_pkg::ex_res_t           src,
        input logic [cpu_pkg::REG_AW-1:0] addr
    );
        return src.valid && src.writes_reg && (src.exc == cpu_pkg::EXC_NONE)
               && (src.dest == addr);
    endfunction

    // nearest producer wins: execute, then result, then register file
    function automatic logic [cpu_pkg::XLEN-1:0] fwd_select(
        input logic [cpu_pkg::REG_AW-1:0] addr,
        input logic [cpu_pkg::XLEN-1:0]   rf_data,
        input cpu_pkg::ex_res_t           ex_src,
        input cpu_pkg::ex_res_t           res_src
    );
        logic [cpu_pkg::XLEN-1:0] val;
        if (fwd_hit(ex_src, addr))
            val = ex_src.data;
        else if (fwd_hit(res_src, addr))
            val = res_src.data;
        else
            val = rf_data;
        return val;
    endfunction

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            pc_q          <= cpu_pkg::RESET_PC;
            fetch_valid_q <= 1'b0;
        end
        else if (flush)
        begin
            pc_q          <= cpu_pkg::EXC_VECTOR;  // redirect to handler
            fetch_valid_q <= 1'b0;                 // kill the slot in decode
        end
        else
        begin
            pc_q          <= pc_q + cpu_pkg::XLEN'(4);
            fetch_valid_q <= 1'b1;
        end
    end

    // payload only, qualified by fetch_valid_q
    always_ff @(posedge SYS_clk)
    begin
        fetch_word_q <= imem_data;
        fetch_pc_q   <= pc_q;
    end

    assign imem_addr = pc_q;

    // instruction fields
    assign opcode  = fetch_word_q[31:26];
    assign rs      = fetch_word_q[25:21];
    assign rt      = fetch_word_q[20:16];
    assign rd      = fetch_word_q[15:11];
    assign funct   = fetch_word_q[5:0];
    assign imm_ext = {{(cpu_pkg::XLEN-16){fetch_word_q[15]}}, fetch_word_q[15:0]};

    assign is_rtype   = (opcode == cpu_pkg::OP_RTYPE);
    assign is_addi    = (opcode == cpu_pkg::OP_ADDI);
    assign slot_valid = fetch_valid_q && (fetch_word_q != '0);  // zero word is a nop
    assign legal      = (is_rtype && funct_ok) || is_addi;

    always_comb
    begin
        rtype_op = cpu_pkg::ALU_ADD;
        funct_ok = 1'b1;
        case (funct)
            cpu_pkg::FN_ADD: rtype_op = cpu_pkg::ALU_ADD;
            cpu_pkg::FN_SUB: rtype_op = cpu_pkg::ALU_SUB;
            cpu_pkg::FN_AND: rtype_op = cpu_pkg::ALU_AND;
            cpu_pkg::FN_OR:  rtype_op = cpu_pkg::ALU_OR;
            cpu_pkg::FN_SLT: rtype_op = cpu_pkg::ALU_SLT;
            default:         funct_ok = 1'b0;
        endcase
    end

    assign rd_addr_a = rs;
    assign rd_addr_b = rt;

    assign op_a = fwd_select(rs, rd_data_a, ex_fwd, res_fwd);
    assign op_b = fwd_select(rt, rd_data_b, ex_fwd, res_fwd);

    always_comb
    begin
        dec_out.valid      = slot_valid;
        dec_out.pc         = fetch_pc_q;
        dec_out.alu_op     = is_addi ? cpu_pkg::ALU_ADD : rtype_op;
        dec_out.opa        = op_a;
        dec_out.opb        = is_addi ? imm_ext : op_b;
        dec_out.dest       = is_addi ? rt : rd;  // addi writes rt
        dec_out.writes_reg = legal;
        dec_out.checks_ovf = is_addi
                             || (is_rtype && (rtype_op == cpu_pkg::ALU_ADD))
                             || (is_rtype && (rtype_op == cpu_pkg::ALU_SUB));
        dec_out.exc        = (slot_valid && !legal) ? cpu_pkg::EXC_ILLEGAL
                                                    : cpu_pkg::EXC_NONE;
    end

endmodule

// ==== dv/tb_top.sv ====
// tb_top: clock, reset, instruction memory model, test programs, reference model and assertions
`timescale 1ns/1ps

module tb_top;

    localparam int WAIT_LIMIT  = 400;  // cycles per wait loop
    localparam int MODEL_STEPS = 150;  // instructions walked by the model per phase

    typedef struct packed {
        logic                       is_exc;
        logic [cpu_pkg::REG_AW-1:0] rd;
        logic [cpu_pkg::XLEN-1:0]   val;   // commit data or epc
        logic [2:0]                 code;
    } rec_t;

    logic                       SYS_clk = 1'b0;
    logic                       SYS_reset = 1'b1;
    logic                       reset_req = 1'b1;
    logic [cpu_pkg::XLEN-1:0]   imem_addr;
    logic [cpu_pkg::XLEN-1:0]   imem_data;
    logic                       commit_valid;
    logic [cpu_pkg::REG_AW-1:0] commit_reg;
    logic [cpu_pkg::XLEN-1:0]   commit_data;
    logic                       exc_valid;
    cpu_pkg::exc_code_t         exc_code;
    logic [cpu_pkg::XLEN-1:0]   epc;

    logic [31:0] imem [logic [29:0]];  // keyed by word address
    rec_t        exp_recs [256];
    int          exp_count = 0;
    int          exp_idx = 0;          // next record the DUT must produce
    rec_t        head;
    logic        head_ok;
    integer      seed;

    cpu_top dut0 (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_data  (commit_data),
        .exc_valid    (exc_valid),
        .exc_code     (exc_code),
        .epc          (epc)
    );

    always #50 SYS_clk = ~SYS_clk;

    always @(posedge SYS_clk)
    begin
        SYS_reset <= reset_req;
        if (SYS_reset)
            exp_idx <= 0;
        else if (commit_valid || exc_valid)
            exp_idx <= exp_idx + 1;  // one record per report cycle
    end

    // unloaded words read as zero
    always_comb
    begin
        imem_data = imem.exists(imem_addr[31:2]) ? imem[imem_addr[31:2]] : '0;
    end

    always_comb
    begin
        head_ok = (exp_idx < exp_count);
        head    = head_ok ? exp_recs[exp_idx] : '0;
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    commit_matches: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        commit_valid |-> (head_ok && !head.is_exc && commit_reg == head.rd
                          && commit_data == head.val))
        else stop_with_failure($sformatf("[ERROR] %0d ns: commit r%0d = %h, expected %h",
                               $time, $sampled(commit_reg), $sampled(commit_data),
                               $sampled(head.val)));

    exc_matches: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        exc_valid |-> (head_ok && head.is_exc && exc_code == head.code && epc == head.val))
        else stop_with_failure($sformatf("[ERROR] %0d ns: exception %0d at epc %h unexpected",
                               $time, $sampled(exc_code), $sampled(epc)));

    redirect_to_vector: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        exc_valid |=> (imem_addr == cpu_pkg::EXC_VECTOR))
        else stop_with_failure($sformatf("[ERROR] %0d ns: fetch not redirected, imem_addr %h",
                               $time, imem_addr));

    function automatic logic [31:0] rtype_word(input logic [5:0] fn, input int rd,
                                               input int rs, input int rt);
        return {cpu_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] addi_word(input int rt, input int rs, input int imm);
        return {cpu_pkg::OP_ADDI, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic load_words(input logic [31:0] base, input logic [31:0] words[$]);
        for (int i = 0; i < words.size(); i++)
            imem[base[31:2] + 30'(i)] = words[i];
    endtask

    task automatic add_record(input logic is_exc, input int rd, input logic [31:0] val,
                              input logic [2:0] code);
        exp_recs[exp_count] = '{is_exc, 5'(rd), val, code};
        exp_count++;
    endtask

    task automatic build_phase(input int ph);
        logic [31:0] prog[$];
        logic [5:0]  fn_list [5] = '{cpu_pkg::FN_ADD, cpu_pkg::FN_SUB, cpu_pkg::FN_AND,
                                     cpu_pkg::FN_OR, cpu_pkg::FN_SLT};
        int          chk;
        int          op;
        imem.delete();
        chk = 1;
        case (ph)
            0:
            begin
                prog.push_back(addi_word(1, 0, 5));
                prog.push_back(addi_word(2, 1, -3));               // needs execute value
                prog.push_back(rtype_word(cpu_pkg::FN_ADD, 3, 1, 2));  // r1 from result stage
                prog.push_back(rtype_word(cpu_pkg::FN_SUB, 4, 3, 1));
                prog.push_back(rtype_word(cpu_pkg::FN_AND, 5, 4, 3));
                prog.push_back(rtype_word(cpu_pkg::FN_OR, 6, 5, 1));
                prog.push_back(addi_word(2, 2, -100));
                prog.push_back(rtype_word(cpu_pkg::FN_SLT, 7, 2, 6));  // negative vs positive
                prog.push_back(32'h0);
                prog.push_back(32'h0);
                for (int i = 0; i < 40; i++)
                begin
                    op = $unsigned($random(seed)) % 6;
                    if (op == 5)
                        prog.push_back(addi_word(1 + $unsigned($random(seed)) % 7,
                                                 1 + $unsigned($random(seed)) % 7,
                                                 $random(seed) % 200));
                    else
                        prog.push_back(rtype_word(fn_list[op], 1 + $unsigned($random(seed)) % 7,
                                                  1 + $unsigned($random(seed)) % 7,
                                                  1 + $unsigned($random(seed)) % 7));
                end
            end
            1:
            begin
                prog.push_back(addi_word(1, 0, 11));
                prog.push_back(addi_word(2, 1, 1));
                prog.push_back(32'hfc00_0000);                 // opcode 0x3f
                prog.push_back(addi_word(3, 0, 1));            // younger, must not commit
                prog.push_back(rtype_word(cpu_pkg::FN_ADD, 4, 1, 2));
                chk = 2;
            end
            2, 3:
            begin
                prog.push_back(addi_word(1, 0, 16'h4000));
                for (int i = 0; i < 16; i++)
                    prog.push_back(rtype_word(cpu_pkg::FN_ADD, 1, 1, 1));  // doubles to 2^30
                prog.push_back(addi_word(3, 1, -1));
                prog.push_back(rtype_word(cpu_pkg::FN_ADD, 4, 1, 3));      // largest positive
                if (ph == 2)
                    prog.push_back(addi_word(4, 4, 1));
                else
                    prog.push_back(rtype_word(cpu_pkg::FN_ADD, 1, 1, 1));
                prog.push_back(rtype_word(cpu_pkg::FN_ADD, 5, 4, 4));
                chk = (ph == 2) ? 4 : 1;
            end
            default:
            begin
                prog.push_back(addi_word(1, 0, 6));
                prog.push_back(addi_word(0, 1, 5));            // r0 target
                prog.push_back(rtype_word(cpu_pkg::FN_ADD, 2, 0, 1));
                chk = 0;
            end
        endcase
        load_words(cpu_pkg::RESET_PC, prog);
        prog.delete();
        prog.push_back(rtype_word(cpu_pkg::FN_ADD, 21, chk, 0));  // handler reads chk
        prog.push_back(rtype_word(cpu_pkg::FN_OR, 22, chk, 1));
        prog.push_back(addi_word(23, 0, 9));
        load_words(cpu_pkg::EXC_VECTOR, prog);
    endtask

    // in-order model of the instruction set, one record per commit or exception
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        longint      sa;
        longint      sb;
        longint      wide;
        logic        legal;
        logic        arith;
        int          dst;
        regs = '{default: '0};
        pc = cpu_pkg::RESET_PC;
        exp_count = 0;
        for (int s = 0; s < MODEL_STEPS; s++)
        begin
            w     = imem.exists(pc[31:2]) ? imem[pc[31:2]] : '0;
            a     = regs[w[25:21]];
            b     = (w[31:26] == cpu_pkg::OP_ADDI) ? {{16{w[15]}}, w[15:0]} : regs[w[20:16]];
            dst   = (w[31:26] == cpu_pkg::OP_ADDI) ? int'(w[20:16]) : int'(w[15:11]);
            sa    = longint'($signed(a));
            sb    = longint'($signed(b));
            legal = 1'b1;
            arith = 1'b1;
            wide  = sa + sb;
            if (w[31:26] != cpu_pkg::OP_ADDI)
            begin
                if (w[31:26] != cpu_pkg::OP_RTYPE)
                    legal = 1'b0;
                else
                    case (w[5:0])
                        cpu_pkg::FN_ADD: wide = sa + sb;
                        cpu_pkg::FN_SUB: wide = sa - sb;
                        cpu_pkg::FN_AND: arith = 1'b0;
                        cpu_pkg::FN_OR:  arith = 1'b0;
                        cpu_pkg::FN_SLT: arith = 1'b0;
                        default:         legal = 1'b0;
                    endcase
                if (w[5:0] == cpu_pkg::FN_AND)
                    wide = longint'(a & b);
                else if (w[5:0] == cpu_pkg::FN_OR)
                    wide = longint'(a | b);
                else if (w[5:0] == cpu_pkg::FN_SLT)
                    wide = (sa < sb) ? 64'sd1 : 64'sd0;
            end
            if (w == '0)
                pc = pc + 4;  // nop
            else if (!legal)
            begin
                add_record(1'b1, 0, pc, 3'd1);
                pc = cpu_pkg::EXC_VECTOR;
            end
            else if (arith && (wide > 64'sd2147483647 || wide < -64'sd2147483648))
            begin
                add_record(1'b1, 0, pc, 3'd2);
                pc = cpu_pkg::EXC_VECTOR;
            end
            else if (dst == 0)
            begin
                add_record(1'b1, 0, pc, 3'd7);
                pc = cpu_pkg::EXC_VECTOR;
            end
            else
            begin
                add_record(1'b0, dst, wide[31:0], 3'd0);
                regs[dst] = wide[31:0];
                pc = pc + 4;
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge SYS_clk);
        reset_req = 1'b1;
        repeat (3) @(negedge SYS_clk);
        reset_req = 1'b0;
        @(negedge SYS_clk);
        reset_pc_ok: assert (imem_addr == cpu_pkg::RESET_PC)
            else stop_with_failure($sformatf("[ERROR] %0d ns: imem_addr %h after reset",
                                   $time, imem_addr));
        for (int i = 0; i < 3; i++)
        begin
            quiet_after_reset: assert (!commit_valid && !exc_valid)
                else stop_with_failure($sformatf("[ERROR] %0d ns: report before first result",
                                       $time));
            @(negedge SYS_clk);
        end
    endtask

    task automatic wait_records(input int ph);
        int cycles;
        cycles = 0;
        while (exp_idx < exp_count)
        begin
            @(negedge SYS_clk);
            cycles++;
            if (cycles > WAIT_LIMIT)
                stop_with_failure($sformatf("timeout: phase %0d saw %0d of %0d records",
                                  ph, exp_idx, exp_count));
        end
        cycles = 0;
        while (cycles < 24)
        begin
            @(negedge SYS_clk);  // idle tail, any extra report trips an assertion
            cycles++;
        end
    endtask

    initial
    begin
        seed = 12;
        for (int ph = 0; ph < 5; ph++)
        begin
            build_phase(ph);  // loaded while fetch is past both program areas
            run_model();
            apply_reset();
            wait_records(ph);
        end
        if (exp_idx == exp_count)
        begin
            $display("TESTS PASSED");
            $finish;
        end
        else
            stop_with_failure("run ended with expected records still outstanding");
    end

endmodule

// ==== execute/alu_execute.sv ====
// alu_execute: execute pipeline register, ALU and signed overflow detection
`timescale 1ns/1ps

module alu_execute (
    input  logic              SYS_clk,
    input  logic              SYS_reset,
    input  logic              flush,
    input  cpu_pkg::dec_ex_t  dec_in,
    output cpu_pkg::ex_res_t  ex_out
);

    localparam int MSB = cpu_pkg::XLEN - 1;

    cpu_pkg::dec_ex_t         ex_q;
    logic [cpu_pkg::XLEN-1:0] sum;
    logic [cpu_pkg::XLEN-1:0] diff;
    logic                     add_ovf;
    logic                     sub_ovf;
    logic [cpu_pkg::XLEN-1:0] alu_result;
    logic                     ovf;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            ex_q <= '0;
        end
        else if (flush)
        begin
            ex_q <= '0;  // younger than the excepting instruction
        end
        else
        begin
            ex_q <= dec_in;
        end
    end

    assign sum  = ex_q.opa + ex_q.opb;
    assign diff = ex_q.opa - ex_q.opb;

    // same-sign operands, result sign flipped
    assign add_ovf = (ex_q.opa[MSB] == ex_q.opb[MSB]) && (sum[MSB] != ex_q.opa[MSB]);
    // opposite-sign operands, result sign differs from minuend
    assign sub_ovf = (ex_q.opa[MSB] != ex_q.opb[MSB]) && (diff[MSB] != ex_q.opa[MSB]);

    always_comb
    begin
        alu_result = sum;
        ovf        = 1'b0;
        case (ex_q.alu_op)
            cpu_pkg::ALU_ADD:
            begin
                alu_result = sum;
                ovf        = add_ovf;
            end
            cpu_pkg::ALU_SUB:
            begin
                alu_result = diff;
                ovf        = sub_ovf;
            end
            cpu_pkg::ALU_AND: alu_result = ex_q.opa & ex_q.opb;
            cpu_pkg::ALU_OR:  alu_result = ex_q.opa | ex_q.opb;
            cpu_pkg::ALU_SLT:
            begin
                alu_result    = '0;
                alu_result[0] = $signed(ex_q.opa) < $signed(ex_q.opb);
            end
            default:          alu_result = sum;
        endcase
    end

    always_comb
    begin
        ex_out.valid      = ex_q.valid;
        ex_out.pc         = ex_q.pc;
        ex_out.dest       = ex_q.dest;
        ex_out.writes_reg = ex_q.writes_reg;
        ex_out.data       = alu_result;  // kept even when trapping
        if (ex_q.exc != cpu_pkg::EXC_NONE)
            ex_out.exc = ex_q.exc;       // decode fault has priority
        else if (ex_q.checks_ovf && ovf)
            ex_out.exc = cpu_pkg::EXC_OVERFLOW;
        else
            ex_out.exc = cpu_pkg::EXC_NONE;
    end

endmodule

// ==== files.f ====
common/cpu_pkg.sv
hw/reg_file.sv
decode/instr_decode.sv
execute/alu_execute.sv
hw/result_commit.sv
hw/cpu_top.sv
dv/tb_top.sv

// ==== hw/cpu_top.sv ====
// cpu_top: four-stage integer core, stage and register file instances
`timescale 1ns/1ps

module cpu_top (
    input  logic                         SYS_clk,
    input  logic                         SYS_reset,
    output logic [cpu_pkg::XLEN-1:0]     imem_addr,
    input  logic [cpu_pkg::XLEN-1:0]     imem_data,
    output logic                         commit_valid,
    output logic [cpu_pkg::REG_AW-1:0]   commit_reg,
    output logic [cpu_pkg::XLEN-1:0]     commit_data,
    output logic                         exc_valid,
    output cpu_pkg::exc_code_t           exc_code,
    output logic [cpu_pkg::XLEN-1:0]     epc
);

    logic [cpu_pkg::REG_AW-1:0] rd_addr_a;
    logic [cpu_pkg::REG_AW-1:0] rd_addr_b;
    logic [cpu_pkg::XLEN-1:0]   rd_data_a;
    logic [cpu_pkg::XLEN-1:0]   rd_data_b;
    logic                       wr_en;
    logic [cpu_pkg::REG_AW-1:0] wr_addr;
    logic [cpu_pkg::XLEN-1:0]   wr_data;
    logic                       flush;     // exception taken at result stage
    cpu_pkg::dec_ex_t           dec_ex;
    cpu_pkg::ex_res_t           ex_res;    // combinational execute result
    cpu_pkg::ex_res_t           res_fwd;   // registered result stage entry

    instr_decode u_decode (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .flush     (flush),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .ex_fwd    (ex_res),
        .res_fwd   (res_fwd),
        .dec_out   (dec_ex)
    );

    alu_execute u_execute (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .flush     (flush),
        .dec_in    (dec_ex),
        .ex_out    (ex_res)
    );

    result_commit u_result (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .res_in       (ex_res),
        .res_fwd      (res_fwd),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_data  (commit_data),
        .exc_valid    (exc_valid),
        .exc_code     (exc_code),
        .epc          (epc),
        .flush        (flush)
    );

    reg_file u_regs (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

endmodule

// ==== hw/reg_file.sv ====
// reg_file: 32 x XLEN register file, two async read ports, one write port
`timescale 1ns/1ps

module reg_file (
    input  logic                         SYS_clk,
    input  logic                         SYS_reset,
    input  logic [cpu_pkg::REG_AW-1:0]   rd_addr_a,
    input  logic [cpu_pkg::REG_AW-1:0]   rd_addr_b,
    output logic [cpu_pkg::XLEN-1:0]     rd_data_a,
    output logic [cpu_pkg::XLEN-1:0]     rd_data_b,
    input  logic                         wr_en,
    input  logic [cpu_pkg::REG_AW-1:0]   wr_addr,
    input  logic [cpu_pkg::XLEN-1:0]     wr_data
);

    localparam int NUM_REGS = 1 << cpu_pkg::REG_AW;

    logic [cpu_pkg::XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[wr_addr] <= wr_data;  // r0 writes are already trapped upstream
        end
    end

    // r0 is hardwired
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

// ==== hw/result_commit.sv ====
// result_commit: result pipeline register, zero-write check, commit, exception report and flush
`timescale 1ns/1ps

module result_commit (
    input  logic                         SYS_clk,
    input  logic                         SYS_reset,
    input  cpu_pkg::ex_res_t             res_in,
    output cpu_pkg::ex_res_t             res_fwd,
    output logic                         wr_en,
    output logic [cpu_pkg::REG_AW-1:0]   wr_addr,
    output logic [cpu_pkg::XLEN-1:0]     wr_data,
    output logic                         commit_valid,
    output logic [cpu_pkg::REG_AW-1:0]   commit_reg,
    output logic [cpu_pkg::XLEN-1:0]     commit_data,
    output logic                         exc_valid,
    output cpu_pkg::exc_code_t           exc_code,
    output logic [cpu_pkg::XLEN-1:0]     epc,
    output logic                         flush
);

    cpu_pkg::ex_res_t res_q;
    logic             zero_write;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            res_q <= '0;
        end
        else if (flush)
        begin
            res_q <= '0;  // drop the younger entry coming from execute
        end
        else
        begin
            res_q <= res_in;
        end
    end

    // r0 target with no earlier fault
    assign zero_write = res_q.valid && res_q.writes_reg && (res_q.dest == '0)
                        && (res_q.exc == cpu_pkg::EXC_NONE);

    always_comb
    begin
        res_fwd = res_q;
        if (zero_write)
            res_fwd.exc = cpu_pkg::EXC_ZERO_WRITE;
    end

    // exception report, one cycle per excepting entry
    assign exc_valid = res_fwd.valid && (res_fwd.exc != cpu_pkg::EXC_NONE);
    assign exc_code  = res_fwd.exc;
    assign epc       = res_fwd.pc;
    assign flush     = exc_valid;

    // commit only when nothing trapped
    assign commit_valid = res_fwd.valid && res_fwd.writes_reg && !exc_valid;
    assign commit_reg   = res_fwd.dest;
    assign commit_data  = res_fwd.data;

    assign wr_en   = commit_valid;
    assign wr_addr = res_fwd.dest;
    assign wr_data = res_fwd.data;

endmodule
